// ==== include/hex_segments.svh ====
// Hex digit segment patterns; included by the shared package and by the testbench
`ifndef hex_segments_svh
`define hex_segments_svh

// Each pattern is abcdefgh with bit 7 as segment a
// A lit segment is 1, and the dot in bit 0 stays dark

`define seg_hex_0 8'b1111_1100
`define seg_hex_1 8'b0110_0000
`define seg_hex_2 8'b1101_1010
`define seg_hex_3 8'b1111_0010
`define seg_hex_4 8'b0110_0110
`define seg_hex_5 8'b1011_0110
`define seg_hex_6 8'b1011_1110
`define seg_hex_7 8'b1110_0000
`define seg_hex_8 8'b1111_1110
`define seg_hex_9 8'b1111_0110
`define seg_hex_a 8'b1110_1110
`define seg_hex_b 8'b0011_1110
`define seg_hex_c 8'b1001_1100
`define seg_hex_d 8'b0111_1010
`define seg_hex_e 8'b1001_1110
`define seg_hex_f 8'b1000_1110

// Full list in index order 0 to f

`define hex_segments_list '{ \
    `seg_hex_0, `seg_hex_1, `seg_hex_2, `seg_hex_3, \
    `seg_hex_4, `seg_hex_5, `seg_hex_6, `seg_hex_7, \
    `seg_hex_8, `seg_hex_9, `seg_hex_a, `seg_hex_b, \
    `seg_hex_c, `seg_hex_d, `seg_hex_e, `seg_hex_f  \
}

`endif

// ==== source/shift_display_pkg.sv ====
// Shared sizes, token table, scan timing and segment patterns, referenced by scoped names

package shift_display_pkg;

    //------------------------------------------------------------------------
    // Datapath sizes
    //------------------------------------------------------------------------

    // Bits per token, one hex digit
    localparam int token_width = 4;

    // Shift stages, also the number of display digits
    localparam int depth = 8;

    // Board push buttons
    localparam int key_width = 4;

    //------------------------------------------------------------------------
    // Token table
    //------------------------------------------------------------------------

    // Fixed permutation of 0..f
    // Walked in order by valid pushes only, so empty slots do not skip entries
    localparam logic [token_width - 1:0] token_table [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb,
        4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha,
        4'hf, 4'h5, 4'h8, 4'h3
    };

    //------------------------------------------------------------------------
    // Display timing and patterns
    //------------------------------------------------------------------------

    // Clock cycles each digit stays selected
    // Kept tiny for simulation, a board build wants thousands
    localparam int scan_period = 4;

    `include "hex_segments.svh"

    // Indexed by token value
    localparam logic [7:0] hex_segments [16] = `hex_segments_list;

    // Shown for a stage without a valid token
    localparam logic [7:0] blank_segments = 8'b0000_0000;

endpackage

// ==== source/token_source.sv ====
// Decode stage instantiated by the shift display top to count valid pushes and look up tokens

`timescale 1ns/1ps

module token_source
(
    input  logic                                         clk,
    input  logic                                         reset,

    // One-cycle push strobe and the key levels
    input  logic                                         step,
    input  logic [shift_display_pkg::key_width   - 1:0] key,

    // Item offered to the shift register
    output logic                                         push_valid,
    output logic [shift_display_pkg::token_width - 1:0] push_data
);

    //------------------------------------------------------------------------
    // Table geometry
    //------------------------------------------------------------------------

    localparam int entries     = $size(shift_display_pkg::token_table);
    localparam int index_width = $clog2(entries);

    //------------------------------------------------------------------------
    // Push counter
    //------------------------------------------------------------------------

    // Index of the token that the next valid push takes
    logic [index_width - 1:0] count;

    // Any key held makes the push a real token
    assign push_valid = | key;

    // Wraps naturally after the last entry
    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (step && push_valid)
            count <= count + 1'b1;
    end

    //------------------------------------------------------------------------
    // Token lookup
    //------------------------------------------------------------------------

    // Combinational read that the shift register samples on the same step
    assign push_data = shift_display_pkg::token_table [count];

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------

    // Empty pushes and idle cycles never move the table index
    count_holds_without_push: assert property
    (
        @(posedge clk) disable iff (reset)
            !(step && push_valid) |=> $stable(count)
    )
    else
        $error("token_source: count moved without a valid step");

endmodule

// ==== source/shift_register_with_valid_and_debug.sv ====
// Execute stage instantiated by the shift display top as a valid-tagged shift register with taps

`timescale 1ns/1ps

module shift_register_with_valid_and_debug
#(
    parameter int width = shift_display_pkg::token_width,
    parameter int depth = shift_display_pkg::depth
)
(
    input  logic                              clk,
    input  logic                              reset,

    // One-cycle shift strobe
    input  logic                              step,

    // New item entering stage 0
    input  logic                              in_valid,
    input  logic [width - 1:0]                in_data,

    // Oldest stage that the next step drops
    output logic                              out_valid,
    output logic [width - 1:0]                out_data,

    // Every stage with stage 0 as the newest
    output logic [depth - 1:0]                tap_valid,
    output logic [depth - 1:0][width - 1:0]   tap_data
);

    //------------------------------------------------------------------------
    // Stage registers
    //------------------------------------------------------------------------

    logic [depth - 1:0]              stage_valid;
    logic [depth - 1:0][width - 1:0] stage_data;

    // Empty slots shift exactly like tokens since there is no back-pressure
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_valid <= '0;
            stage_data  <= '0;
        end
        else if (step)
        begin
            stage_valid [0] <= in_valid;
            stage_data  [0] <= in_data;

            for (int k = 1; k < depth; k++)
            begin
                stage_valid [k] <= stage_valid [k - 1];
                stage_data  [k] <= stage_data  [k - 1];
            end
        end
    end

    //------------------------------------------------------------------------
    // Outputs
    //------------------------------------------------------------------------

    assign out_valid = stage_valid [depth - 1];
    assign out_data  = stage_data  [depth - 1];

    // Debug taps for the display
    assign tap_valid = stage_valid;
    assign tap_data  = stage_data;

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------

    // Between steps the whole register is frozen
    stages_hold_without_step: assert property
    (
        @(posedge clk) disable iff (reset)
            !step |=> $stable(stage_valid) && $stable(stage_data)
    )
    else
        $error("shift register: a stage changed without step");

endmodule

// ==== source/seven_segment_display.sv ====
// Result stage of the shift display; scans the digits, encodes hex and blanks empty stages

`timescale 1ns/1ps

module seven_segment_display
#(
    parameter int digits = shift_display_pkg::depth
)
(
    input  logic                                                        clk,
    input  logic                                                        reset,

    // One value per digit, digit 0 is the rightmost
    input  logic [digits - 1:0][shift_display_pkg::token_width - 1:0] number,
    input  logic [digits - 1:0]                                         number_valid,

    // Segment lines and one-hot digit select
    output logic [7:0]                                                  abcdefgh,
    output logic [digits - 1:0]                                         digit
);

    //------------------------------------------------------------------------
    // Scan timing
    //------------------------------------------------------------------------

    localparam int scan_width = shift_display_pkg::scan_period > 1
                              ? $clog2(shift_display_pkg::scan_period)
                              : 1;

    localparam logic [scan_width - 1:0] scan_last =
        scan_width'(shift_display_pkg::scan_period - 1);

    logic [scan_width - 1:0] scan_count;
    logic                    scan_wrap;

    assign scan_wrap = (scan_count == scan_last);

    always_ff @(posedge clk)
    begin
        if (reset)
            scan_count <= '0;
        else if (scan_wrap)
            scan_count <= '0;
        else
            scan_count <= scan_count + 1'b1;
    end

    //------------------------------------------------------------------------
    // Digit select
    //------------------------------------------------------------------------

    logic [digits - 1:0] digit_next;

    // Rotate left with wrap from the top digit back to digit 0
    assign digit_next = scan_wrap ? ((digit << 1) | (digit >> (digits - 1)))
                                  : digit;

    //------------------------------------------------------------------------
    // Segment encoding
    //------------------------------------------------------------------------

    logic [shift_display_pkg::token_width - 1:0] selected_number;
    logic                                        selected_valid;
    logic [7:0]                                  segments_next;

    // Pick the value for the digit that is about to be lit
    always_comb
    begin
        selected_number = '0;
        selected_valid  = 1'b0;

        for (int i = 0; i < digits; i++)
        begin
            if (digit_next [i])
            begin
                selected_number = number       [i];
                selected_valid  = number_valid [i];
            end
        end
    end

    assign segments_next = selected_valid
                         ? shift_display_pkg::hex_segments [selected_number]
                         : shift_display_pkg::blank_segments;

    // Segments and select change on the same edge, so no ghosting
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            digit    <= digits'(1);
            abcdefgh <= shift_display_pkg::blank_segments;
        end
        else
        begin
            digit    <= digit_next;
            abcdefgh <= segments_next;
        end
    end

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------

    digit_one_hot: assert property
    (
        @(posedge clk) disable iff (reset)
            $onehot(digit)
    )
    else
        $error("display: digit select is not one-hot");

endmodule

// ==== source/shift_display_top.sv ====
// Top level of the shift display demo; wires token source, shift register and display

`timescale 1ns/1ps

module shift_display_top
(
    input  logic                                         clk,
    input  logic                                         reset,

    // Push strobe and keys
    input  logic                                         step,
    input  logic [shift_display_pkg::key_width   - 1:0] key,

    // Multiplexed seven-segment display
    output logic [7:0]                                   abcdefgh,
    output logic [shift_display_pkg::depth       - 1:0] digit,

    // Oldest stage of the shift register
    output logic                                         out_valid,
    output logic [shift_display_pkg::token_width - 1:0] out_data
);

    //------------------------------------------------------------------------
    // Decode
    //------------------------------------------------------------------------

    logic                                        push_valid;
    logic [shift_display_pkg::token_width - 1:0] push_data;

    token_source i_source
    (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .key        (key),
        .push_valid (push_valid),
        .push_data  (push_data)
    );

    //------------------------------------------------------------------------
    // Execute
    //------------------------------------------------------------------------

    logic [shift_display_pkg::depth - 1:0]                                        tap_valid;
    logic [shift_display_pkg::depth - 1:0][shift_display_pkg::token_width - 1:0] tap_data;

    shift_register_with_valid_and_debug
    #(
        .width (shift_display_pkg::token_width),
        .depth (shift_display_pkg::depth)
    )
    i_shift
    (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .in_valid  (push_valid),
        .in_data   (push_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .tap_valid (tap_valid),
        .tap_data  (tap_data)
    );

    //------------------------------------------------------------------------
    // Result
    //------------------------------------------------------------------------

    logic [shift_display_pkg::depth - 1:0]                                        shown_valid;
    logic [shift_display_pkg::depth - 1:0][shift_display_pkg::token_width - 1:0] shown_data;

    // Newest stage on the leftmost digit
    for (genvar i = 0; i < shift_display_pkg::depth; i++)
    begin : gen_mirror
        assign shown_valid [i] = tap_valid [shift_display_pkg::depth - 1 - i];
        assign shown_data  [i] = tap_data  [shift_display_pkg::depth - 1 - i];
    end

    seven_segment_display
    #(
        .digits (shift_display_pkg::depth)
    )
    i_display
    (
        .clk          (clk),
        .reset        (reset),
        .number       (shown_data),
        .number_valid (shown_valid),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

endmodule

// ==== bench/tb_shift_display.sv ====
// Self-checking testbench for the shift display top level; build it with the RTL from compile.f

`timescale 1ns/1ps

`include "hex_segments.svh"

module tb_shift_display;

    //------------------------------------------------------------------------
    // Run length
    //------------------------------------------------------------------------

    localparam int clock_period = 100;
    localparam int reset_cycles = 16;
    localparam int step_count   = 400;
    localparam int max_gap      = 5;

    localparam int depth       = shift_display_pkg::depth;
    localparam int token_width = shift_display_pkg::token_width;

    // Long enough to walk the scan over every digit twice
    localparam int drain_cycles = 2 * depth * shift_display_pkg::scan_period;

    // Worst case stimulus length plus drain and slack
    localparam int watchdog_cycles =
        step_count * (max_gap + 1) + reset_cycles + drain_cycles + 100;

    // Reference copy of the segment patterns
    localparam logic [7:0] segment_table [16] = `hex_segments_list;

    //------------------------------------------------------------------------
    // DUT
    //------------------------------------------------------------------------

    logic                                        clk;
    logic                                        reset;
    logic                                        step;
    logic [shift_display_pkg::key_width - 1:0]   key;
    logic [7:0]                                  abcdefgh;
    logic [depth - 1:0]                          digit;
    logic                                        out_valid;
    logic [token_width - 1:0]                    out_data;

    shift_display_top i_dut
    (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .key       (key),
        .abcdefgh  (abcdefgh),
        .digit     (digit),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(clock_period / 2) clk = ~clk;

    //------------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------------

    logic [3:0]                              model_count;
    logic [depth - 1:0]                      model_valid;
    logic [depth - 1:0][token_width - 1:0]   model_data;
    logic [depth - 1:0]                      prev_valid;
    logic [depth - 1:0][token_width - 1:0]   prev_data;
    logic [depth - 1:0]                      model_digit;
    logic [token_width:0]                    last_out;
    logic                                    reset_d;
    int                                      scan_ticks;
    int                                      cycle_count    = 0;
    int                                      valid_left     = 0;
    int                                      empty_left     = 0;
    int                                      reset_errors   = 0;
    int                                      data_errors    = 0;
    int                                      display_errors = 0;
    int                                      scan_errors    = 0;
    int                                      stimulus_errors = 0;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        reset_d     <= reset;
        prev_valid  <= model_valid;
        prev_data   <= model_data;
        last_out    <= {out_valid, out_data};

        if (reset)
        begin
            model_count <= '0;
            model_valid <= '0;
            model_data  <= '0;
            model_digit <= depth'(1);
            scan_ticks  <= 0;
        end
        else
        begin
            // Every step pushes, a released key only makes the slot empty
            if (step)
            begin
                model_valid <= {model_valid [depth - 2:0], |key};
                model_data  <= {model_data [depth - 2:0],
                                shift_display_pkg::token_table [model_count]};
                if (|key)
                    model_count <= model_count + 4'd1;
                if (model_valid [depth - 1])
                    valid_left <= valid_left + 1;
                else
                    empty_left <= empty_left + 1;
            end

            if (scan_ticks == shift_display_pkg::scan_period - 1)
            begin
                scan_ticks  <= 0;
                model_digit <= {model_digit [depth - 2:0], model_digit [depth - 1]};
            end
            else
                scan_ticks <= scan_ticks + 1;
        end
    end

    // Digit i shows stage depth - 1 - i, blank when that stage is empty
    function automatic logic [7:0] expected_segments
    (
        input logic [depth - 1:0]                    select,
        input logic [depth - 1:0]                    valid,
        input logic [depth - 1:0][token_width - 1:0] data
    );
        logic [7:0] pattern;

        pattern = shift_display_pkg::blank_segments;
        for (int i = 0; i < depth; i++)
            if (select [i] && valid [depth - 1 - i])
                pattern = segment_table [data [depth - 1 - i]];
        return pattern;
    endfunction

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------

    logic in_reset_window;
    logic checking;

    // First edge skipped, outputs are still unknown there
    assign in_reset_window = (cycle_count != 0) && (reset || reset_d);
    assign checking        = (cycle_count != 0) && !reset && !reset_d;

    reset_out_valid: assert property (@(posedge clk) in_reset_window |-> !out_valid)
    else
    begin
        reset_errors++;
        $display("Error at %0t: out_valid expected 0, actual %b", $time, $sampled(out_valid));
    end

    reset_segments: assert property
        (@(posedge clk) in_reset_window |-> abcdefgh == shift_display_pkg::blank_segments)
    else
    begin
        reset_errors++;
        $display("Error at %0t: abcdefgh expected %b, actual %b", $time,
                 shift_display_pkg::blank_segments, $sampled(abcdefgh));
    end

    reset_digit: assert property (@(posedge clk) in_reset_window |-> digit == depth'(1))
    else
    begin
        reset_errors++;
        $display("Error at %0t: digit expected %b, actual %b", $time,
                 depth'(1), $sampled(digit));
    end

    out_valid_matches: assert property
        (@(posedge clk) checking |-> out_valid == model_valid [depth - 1])
    else
    begin
        data_errors++;
        $display("Error at %0t: out_valid expected %b, actual %b", $time,
                 $sampled(model_valid [depth - 1]), $sampled(out_valid));
    end

    // Data of an empty slot is not part of the token sequence
    out_data_matches: assert property
        (@(posedge clk) checking && model_valid [depth - 1] |-> out_data == model_data [depth - 1])
    else
    begin
        data_errors++;
        $display("Error at %0t: out_data expected %h, actual %h", $time,
                 $sampled(model_data [depth - 1]), $sampled(out_data));
    end

    outputs_hold: assert property
        (@(posedge clk) disable iff (!checking) !step |=> {out_valid, out_data} == last_out)
    else
    begin
        data_errors++;
        $display("Error at %0t: {out_valid, out_data} expected %h, actual %h", $time,
                 $sampled(last_out), $sampled({out_valid, out_data}));
    end

    digit_rotates: assert property (@(posedge clk) checking |-> digit == model_digit)
    else
    begin
        scan_errors++;
        $display("Error at %0t: digit expected %b, actual %b", $time,
                 $sampled(model_digit), $sampled(digit));
    end

    segments_match: assert property
        (@(posedge clk) checking |-> abcdefgh == expected_segments(digit, prev_valid, prev_data))
    else
    begin
        display_errors++;
        $display("Error at %0t: abcdefgh expected %b, actual %b", $time,
                 expected_segments($sampled(digit), $sampled(prev_valid), $sampled(prev_data)),
                 $sampled(abcdefgh));
    end

    //------------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------------

    initial
    begin
        int         seed;
        int         gap;
        int         stretch_left;
        logic [3:0] held;

        seed         = 32'hadee_a01d;
        stretch_left = 0;
        held         = '0;
        clk          = 1'b0;
        reset        = 1'b1;
        step         = 1'b0;
        key          = '0;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int n = 0; n < step_count; n++)
        begin
            // Keys stay put for a stretch of steps, about a third of them released
            if (stretch_left == 0)
            begin
                stretch_left = 1 + {$random(seed)} % 6;
                held = ({$random(seed)} % 3 == 0) ? 4'b0000 : 4'($random(seed));
            end
            stretch_left--;

            key  <= held;
            step <= 1'b1;
            @(posedge clk);
            // A zero gap lets the next pass raise step again on this edge
            step <= 1'b0;
            gap = {$random(seed)} % (max_gap + 1);
            repeat (gap) @(posedge clk);
        end

        key <= '0;
        repeat (drain_cycles) @(posedge clk);

        if (valid_left <= 16)
        begin
            stimulus_errors++;
            $display("Stimulus too short: the token table never wrapped at out_data");
        end
        if (empty_left == 0)
        begin
            stimulus_errors++;
            $display("Stimulus never sent an empty slot out of the register");
        end

        $display("Errors: reset %0d, data %0d, display %0d, scan %0d, stimulus %0d",
                 reset_errors, data_errors, display_errors, scan_errors, stimulus_errors);
        if (reset_errors + data_errors + display_errors + scan_errors + stimulus_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
source/shift_display_pkg.sv
source/token_source.sv
source/shift_register_with_valid_and_debug.sv
source/seven_segment_display.sv
source/shift_display_top.sv
bench/tb_shift_display.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the shift display testbench with Verilator
# Exit status is nonzero when the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -f compile.f --top-module tb_shift_display -o sim_shift_display
if [ $? -ne 0 ]
then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_shift_display > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]
then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"
then
    echo "Simulation reported failures, see $log"
    exit 1
fi

echo "Simulation passed, see $log"
exit 0
